// ==== sources.f ====
src/enc_cfg_pkg.sv
src/enc_fsm_pkg.sv
src/sram.sv
src/matcher.sv
src/encoder.sv
src/encoder_top.sv
tests/encoder_chk.sv
tests/encoder_tb.sv

// ==== tests/encoder_tb.sv ====
`default_nettype none

module encoder_tb
    import enc_cfg_pkg::*;
;

    localparam int N_ROWS = 8;
    localparam int CYCLE_LIMIT = N_ROWS * 10000 + 1000;

    // words are space separated here, '#n' is the token for vocabulary word n, '.' is SEP
    string vocab_tab [N_ROWS] = '{"the cat", "a the cat sat on mat", "the cat", "cat dog",
                                  "the cat sat", "the cat sat", "sat cat the", "the cat sat"};
    string input_tab [N_ROWS] = '{"", "a sat mat", "dog xyz", "ca cats", "the dog sat on it",
                                  "the dog sat on it", "the cat sat", "the cat sat"};
    string expect_tab [N_ROWS] = '{"", "#0#3#5", "dog.xyz.", "ca.cats.", "#0dog.#2on.it.",
                                   "#0dog.#2on.it.", "#2#1#0", "#0#1#2"};
    int    len_tab [N_ROWS] = '{0, 3, 8, 8, 12, 12, 3, 3};
    bit    poke_tab [N_ROWS] = '{0, 0, 0, 0, 0, 1, 0, 0};    // second start pulse mid-run

    logic  clk;
    logic  rst_n;
    logic  start;
    logic  load_input_we;
    logic  load_vocab_we;
    addr_t load_addr;
    char_t load_data;
    addr_t rd_addr;
    char_t rd_data;
    logic  busy;
    logic  done;
    addr_t out_len;

    integer seed = 32'hc6f83320;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    char_t  exp_bytes [DEPTH];
    int     exp_count;

    encoder_top uut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_char(input char_t got, input char_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at time %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_len(input addr_t got, input addr_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at time %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at time %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // junk goes beyond the terminators so a read past them shows up as a wrong result
    task automatic load_ram(input logic to_vocab, input string words);
        char_t image [DEPTH];
        int    n;
        n = words.len();
        for (int i = 0; i < DEPTH; i++) begin
            image[i] = char_t'($random(seed));
        end
        for (int i = 0; i < n; i++) begin
            image[i] = (words[i] == " ") ? SEP : char_t'(words[i]);
        end
        image[n] = SEP;
        if (n > 0) begin
            image[n + 1] = SEP;    // the empty word that ends the string
        end
        for (int a = 0; a < DEPTH; a++) begin
            load_addr = addr_t'(a);
            load_data = image[a];
            load_vocab_we = to_vocab;
            load_input_we = !to_vocab;
            next_cycle();
        end
        load_vocab_we = 1'b0;
        load_input_we = 1'b0;
    endtask

    task automatic build_expected(input string s);
        int i;
        i = 0;
        exp_count = 0;
        while (i < s.len()) begin
            if (s[i] == "#") begin
                exp_bytes[exp_count] = TOKEN_FLAG | char_t'(s[i + 1] - 8'h30);
                i = i + 2;
            end else begin
                exp_bytes[exp_count] = (s[i] == ".") ? SEP : char_t'(s[i]);
                i = i + 1;
            end
            exp_count++;
        end
    endtask

    task automatic wait_done(input int row);
        int n;
        n = 0;
        while (!done && n < 10000) begin
            next_cycle();
            n++;
        end
        if (!done) begin
            errors++;
            $display("done never rose for case %0d", row);
        end
    endtask

    task automatic run_case(input int row);
        load_ram(1'b0, input_tab[row]);
        load_ram(1'b1, vocab_tab[row]);
        build_expected(expect_tab[row]);
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        if (poke_tab[row]) begin
            next_cycle();
            next_cycle();
            check_flag(busy, 1'b1, "busy before second start");
            start = 1'b1;    // must be ignored while busy
            next_cycle();
            start = 1'b0;
        end
        wait_done(row);
        if (done) begin
            check_len(out_len, addr_t'(len_tab[row]), $sformatf("case %0d out_len", row));
            check_flag(busy, 1'b0, "busy at done");
            for (int i = 0; i < exp_count; i++) begin
                rd_addr = addr_t'(i);
                next_cycle();
                check_char(rd_data, exp_bytes[i], $sformatf("case %0d byte %0d", row, i));
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b1;
        start = 1'b0;
        load_input_we = 1'b0;
        load_vocab_we = 1'b0;
        load_addr = '0;
        load_data = '0;
        rd_addr = '0;
        #1 rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #2 rst_n = 1'b1;
        next_cycle();
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(done, 1'b0, "done after reset");
        check_len(out_len, '0, "out_len after reset");
        for (int row = 0; row < N_ROWS; row++) begin
            run_case(row);
        end
        next_cycle();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/encoder_chk.sv ====
`default_nettype none

module encoder_chk (
    input wire clk,
    input wire rst_n,
    input wire busy,
    input wire done,
    input wire out_we,
    input wire match_start
);

    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // done marks the end of a run, so busy was high just before it
    done_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(busy))
        else $error("done without busy in the previous cycle");

    write_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        out_we |-> busy)
        else $error("output write while idle");

    match_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        match_start |-> busy)
        else $error("matcher started while idle");

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!busy && !done && !out_we))
        else $error("control outputs active during reset");

endmodule

bind encoder encoder_chk u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .busy        (busy),
    .done        (done),
    .out_we      (out_we),
    .match_start (match_start)
);

`default_nettype wire

// ==== src/encoder_top.sv ====
`default_nettype none

module encoder_top
    import enc_cfg_pkg::*;
(
    input  wire   clk,
    input  wire   rst_n,
    input  wire   start,
    input  wire   load_input_we,
    input  wire   load_vocab_we,
    input  addr_t load_addr,
    input  char_t load_data,
    input  addr_t rd_addr,
    output char_t rd_data,
    output logic  busy,
    output logic  done,
    output addr_t out_len
);

    addr_t  input_rd_addr;
    char_t  input_rd_data;
    addr_t  vocab_rd_addr;
    char_t  vocab_rd_data;
    addr_t  match_input_addr;
    addr_t  match_addr;
    logic   match_start;
    logic   match_done;
    logic   match_found;
    token_t match_index;
    logic   out_we;
    addr_t  out_addr;
    char_t  out_data;

    sram #(.ADDR_W(ADDR_W), .DATA_W(CHAR_W)) input_ram (
        .clk     (clk),
        .we      (load_input_we),
        .wr_addr (load_addr),
        .wr_data (load_data),
        .rd_addr (input_rd_addr),
        .rd_data (input_rd_data)
    );

    sram #(.ADDR_W(ADDR_W), .DATA_W(CHAR_W)) vocab_ram (
        .clk     (clk),
        .we      (load_vocab_we),
        .wr_addr (load_addr),
        .wr_data (load_data),
        .rd_addr (vocab_rd_addr),
        .rd_data (vocab_rd_data)
    );

    sram #(.ADDR_W(ADDR_W), .DATA_W(CHAR_W)) output_ram (
        .clk     (clk),
        .we      (out_we),
        .wr_addr (out_addr),
        .wr_data (out_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    matcher u_matcher (
        .clk           (clk),
        .rst_n         (rst_n),
        .match_start   (match_start),
        .match_addr    (match_addr),
        .vocab_rd_addr (vocab_rd_addr),
        .vocab_rd_data (vocab_rd_data),
        .input_rd_addr (match_input_addr),
        .input_rd_data (input_rd_data),
        .match_done    (match_done),
        .match_found   (match_found),
        .match_index   (match_index)
    );

    encoder u_encoder (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .busy             (busy),
        .done             (done),
        .out_len          (out_len),
        .input_rd_addr    (input_rd_addr),
        .input_rd_data    (input_rd_data),
        .match_input_addr (match_input_addr),
        .match_start      (match_start),
        .match_addr       (match_addr),
        .match_done       (match_done),
        .match_found      (match_found),
        .match_index      (match_index),
        .out_we           (out_we),
        .out_addr         (out_addr),
        .out_data         (out_data)
    );

endmodule

`default_nettype wire

// ==== src/encoder.sv ====
`default_nettype none

module encoder
    import enc_cfg_pkg::*, enc_fsm_pkg::*;
(
    input  wire    clk,
    input  wire    rst_n,
    input  wire    start,
    output logic   busy,
    output logic   done,
    output addr_t  out_len,
    output addr_t  input_rd_addr,
    input  char_t  input_rd_data,
    input  addr_t  match_input_addr,
    output logic   match_start,
    output addr_t  match_addr,
    input  wire    match_done,
    input  wire    match_found,
    input  token_t match_index,
    output logic   out_we,
    output addr_t  out_addr,
    output char_t  out_data
);

    enc_state_t state;
    addr_t      rd_ptr;        // start of the current word, then the scan position
    addr_t      wr_ptr;
    token_t     tok_q;
    logic       end_q;         // the last input byte has been consumed
    logic       last_byte;
    logic       stop;
    logic       at_sep;

    assign last_byte = (rd_ptr == addr_t'(DEPTH - 1));
    assign at_sep = (input_rd_data == SEP);
    assign stop = at_sep || end_q;

    // the matcher drives the input ram only while a match is running
    assign input_rd_addr = (state == ENC_MATCH_WAIT) ? match_input_addr : rd_ptr;
    assign match_addr = rd_ptr;
    assign match_start = (state == ENC_MATCH_START) && !stop;

    assign out_addr = wr_ptr;
    assign out_we = (state == ENC_SEP_WR) || (state == ENC_TOKEN_WR) ||
                    ((state == ENC_COPY) && !at_sep);

    always_comb begin
        case (state)
            ENC_TOKEN_WR: out_data = TOKEN_FLAG | {1'b0, tok_q};
            ENC_COPY:     out_data = input_rd_data;
            default:      out_data = SEP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == ENC_MATCH_WAIT && match_done) begin
            tok_q <= match_index;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ENC_IDLE;
            rd_ptr <= '0;
            wr_ptr <= '0;
            end_q <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
            out_len <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                ENC_IDLE: begin
                    // rd_ptr is parked at 0, so the first byte is already being read
                    if (start) begin
                        busy <= 1'b1;
                        wr_ptr <= '0;
                        end_q <= 1'b0;
                        state <= ENC_MATCH_START;
                    end
                end
                ENC_MATCH_START: begin
                    state <= stop ? ENC_FINISH : ENC_MATCH_WAIT;
                end
                ENC_MATCH_WAIT: begin
                    if (match_done) begin
                        state <= match_found ? ENC_SKIP_RD : ENC_COPY_RD;
                    end
                end
                ENC_SKIP_RD: begin
                    state <= ENC_SKIP;
                end
                ENC_SKIP: begin
                    rd_ptr <= rd_ptr + 1'b1;
                    end_q <= last_byte;
                    // the token goes out once rd_ptr already points at the next word
                    state <= (at_sep || last_byte) ? ENC_TOKEN_WR : ENC_SKIP_RD;
                end
                ENC_COPY_RD: begin
                    state <= ENC_COPY;
                end
                ENC_COPY: begin
                    rd_ptr <= rd_ptr + 1'b1;
                    end_q <= last_byte;
                    if (!at_sep) begin
                        wr_ptr <= wr_ptr + 1'b1;
                    end
                    state <= (at_sep || last_byte) ? ENC_SEP_WR : ENC_COPY_RD;
                end
                ENC_SEP_WR: begin
                    wr_ptr <= wr_ptr + 1'b1;
                    state <= ENC_MATCH_START;
                end
                ENC_TOKEN_WR: begin
                    wr_ptr <= wr_ptr + 1'b1;
                    state <= ENC_MATCH_START;
                end
                ENC_FINISH: begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    out_len <= wr_ptr;
                    rd_ptr <= '0;
                    state <= ENC_IDLE;
                end
                default: begin
                    state <= ENC_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/matcher.sv ====
`default_nettype none

module matcher
    import enc_cfg_pkg::*, enc_fsm_pkg::*;
(
    input  wire    clk,
    input  wire    rst_n,
    input  wire    match_start,
    input  addr_t  match_addr,
    output addr_t  vocab_rd_addr,
    input  char_t  vocab_rd_data,
    output addr_t  input_rd_addr,
    input  char_t  input_rd_data,
    output logic   match_done,
    output logic   match_found,
    output token_t match_index
);

    match_state_t state;
    addr_t        vocab_ptr;
    addr_t        input_ptr;
    token_t       index_q;
    logic         found_q;
    logic         word_start;      // vocab_ptr sits on the first byte of a vocabulary word
    logic         vocab_last;
    logic         bytes_equal;

    assign vocab_last = (vocab_ptr == addr_t'(DEPTH - 1));
    assign bytes_equal = (vocab_rd_data == input_rd_data);

    assign vocab_rd_addr = vocab_ptr;
    assign input_rd_addr = input_ptr;

    assign match_done = (state == M_REPORT);
    assign match_found = found_q;
    assign match_index = index_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= M_IDLE;
            vocab_ptr <= '0;
            input_ptr <= '0;
            index_q <= '0;
            found_q <= 1'b0;
            word_start <= 1'b0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (match_start) begin
                        vocab_ptr <= '0;
                        input_ptr <= match_addr;
                        index_q <= '0;
                        found_q <= 1'b0;
                        word_start <= 1'b1;
                        state <= M_FETCH;
                    end
                end
                M_FETCH: begin
                    state <= M_COMPARE;    // both rams return data next cycle
                end
                M_COMPARE: begin
                    if (word_start && vocab_rd_data == SEP) begin
                        state <= M_REPORT;    // empty vocabulary word, nothing left to try
                    end else if (bytes_equal && vocab_rd_data == SEP) begin
                        found_q <= 1'b1;
                        state <= M_REPORT;
                    end else if (!bytes_equal) begin
                        // the address is unchanged, so SKIP sees the same vocabulary byte
                        state <= M_SKIP;
                    end else if (vocab_last) begin
                        state <= M_REPORT;
                    end else begin
                        vocab_ptr <= vocab_ptr + 1'b1;
                        input_ptr <= input_ptr + 1'b1;
                        word_start <= 1'b0;
                        state <= M_FETCH;
                    end
                end
                M_SKIP_FETCH: begin
                    state <= M_SKIP;
                end
                M_SKIP: begin
                    if (vocab_last) begin
                        state <= M_REPORT;
                    end else begin
                        vocab_ptr <= vocab_ptr + 1'b1;
                        if (vocab_rd_data == SEP) begin
                            input_ptr <= match_addr;    // retry the word against the next entry
                            index_q <= index_q + 1'b1;
                            word_start <= 1'b1;
                            state <= M_FETCH;
                        end else begin
                            state <= M_SKIP_FETCH;
                        end
                    end
                end
                M_REPORT: begin
                    state <= M_IDLE;
                end
                default: begin
                    state <= M_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/sram.sv ====
`default_nettype none

module sram #(
    parameter int ADDR_W = 6,
    parameter int DATA_W = 8
) (
    input  wire               clk,
    input  wire               we,
    input  wire  [ADDR_W-1:0] wr_addr,
    input  wire  [DATA_W-1:0] wr_data,
    input  wire  [ADDR_W-1:0] rd_addr,
    output logic [DATA_W-1:0] rd_data
);

    logic [DATA_W-1:0] mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];    // old contents when both ports hit the same address
    end

endmodule

`default_nettype wire

// ==== src/enc_fsm_pkg.sv ====
`default_nettype none

package enc_fsm_pkg;

    typedef enum logic [3:0] {
        ENC_IDLE,
        ENC_MATCH_START,
        ENC_MATCH_WAIT,
        ENC_SKIP_RD,
        ENC_SKIP,
        ENC_COPY_RD,
        ENC_COPY,
        ENC_SEP_WR,
        ENC_TOKEN_WR,
        ENC_FINISH
    } enc_state_t;

    typedef enum logic [2:0] {
        M_IDLE,
        M_FETCH,
        M_COMPARE,
        M_SKIP_FETCH,
        M_SKIP,
        M_REPORT
    } match_state_t;

endpackage

`default_nettype wire

// ==== src/enc_cfg_pkg.sv ====
`default_nettype none

package enc_cfg_pkg;

    localparam int ADDR_W = 6;
    localparam int DEPTH = 2 ** ADDR_W;    // bytes in each ram
    localparam int CHAR_W = 8;
    localparam int TOKEN_W = 7;             // enough for 127 vocabulary words

    typedef logic [CHAR_W-1:0] char_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [TOKEN_W-1:0] token_t;

    // every emitted token byte has the top bit set, literal characters never do
    localparam char_t TOKEN_FLAG = 8'h80;
    localparam char_t SEP = 8'h00;          // ends a word, an empty word ends the string

endpackage

`default_nettype wire
